// ==== src/hn_noc_pkg.sv ====
package hn_noc_pkg;

  // mesh coordinates
  parameter int NODE_X_W = 3;
  parameter int NODE_Y_W = 3;

  typedef logic [NODE_X_W-1:0] node_x_t;
  typedef logic [NODE_Y_W-1:0] node_y_t;

  typedef struct packed {
    node_x_t x;
    node_y_t y;
  } node_id_t;

  // router output ports with L as the local port
  typedef enum logic [2:0] {
    N = 3'd0,
    S = 3'd1,
    E = 3'd2,
    W = 3'd3,
    L = 3'd4
  } io_port_t;

  parameter int VC_ID_W = 2;
  typedef logic [VC_ID_W-1:0] vc_id_t;

  parameter int TXN_ID_W = 8;
  typedef logic [TXN_ID_W-1:0] txn_id_t;

  // one flit format for every channel
  typedef struct packed {
    node_id_t    tgt_id;
    node_id_t    src_id;
    logic [4:0]  opcode;
    txn_id_t     txn_id;
    logic [31:0] payload;
  } hn_flit_t;

  // one direction of a router link
  typedef struct packed {
    logic     v;
    vc_id_t   vc_id;
    io_port_t route;
    hn_flit_t flit;
  } hn_link_t;

  // credit pulse
  typedef struct packed {
    logic   v;
    vc_id_t id;
  } hn_lcrd_t;

  // channels the home agent sends on
  parameter int TX_CH_NUM = 3;
  parameter int TX_RESP   = 0;
  parameter int TX_DATA   = 1;
  parameter int TX_SNP    = 2;

  // channels the home agent receives on
  parameter int RX_CH_NUM = 4;
  parameter int RX_REQ    = 0;
  parameter int RX_RESP   = 1;
  parameter int RX_EVICT  = 2;
  parameter int RX_DATA   = 3;

endpackage

// ==== src/hn_route_dec.sv ====
`timescale 1ns/100ps

module hn_route_dec
  import hn_noc_pkg::*;
(
  input  node_id_t node_id_i,
  input  hn_flit_t flit_i,
  output hn_flit_t flit_o,
  output io_port_t route_o
);

  node_x_t tgt_x;
  node_y_t tgt_y;
  node_x_t own_x;
  node_y_t own_y;

  assign tgt_x = flit_i.tgt_id.x;
  assign tgt_y = flit_i.tgt_id.y;
  assign own_x = node_id_i.x;
  assign own_y = node_id_i.y;

  // flit leaves with this tile as its source
  always_comb begin
    flit_o        = flit_i;
    flit_o.src_id = node_id_i;
  end

  // x first, then y
  always_comb begin
    if (tgt_x > own_x) begin
      route_o = E;
    end else if (tgt_x < own_x) begin
      route_o = W;
    end else if (tgt_y > own_y) begin
      route_o = N;
    end else if (tgt_y < own_y) begin
      route_o = S;
    end else begin
      // target is this tile
      route_o = L;
    end
  end

endmodule

// ==== src/hn_credit_tracker.sv ====
`timescale 1ns/100ps

module hn_credit_tracker
  import hn_noc_pkg::*;
#(
  parameter int VC_NUM   = 2,
  parameter int VC_DEPTH = 4
) (
  input  logic     clk,
  input  logic     rst_n_i,
  input  logic     take_i,
  input  hn_lcrd_t lcrd_i,
  output logic     rdy_o,
  output vc_id_t   vc_id_o
);

  localparam int CNT_W = $clog2(VC_DEPTH + 1);

  typedef logic [CNT_W-1:0] crd_cnt_t;

  crd_cnt_t          cnt_q [VC_NUM];
  logic [VC_NUM-1:0] vc_avail;

  // lowest vc with credit left wins
  always_comb begin
    vc_id_o = '0;
    for (int v = VC_NUM - 1; v >= 0; v--) begin
      if (vc_avail[v]) begin
        vc_id_o = vc_id_t'(v);
      end
    end
  end

  assign rdy_o = |vc_avail;

  for (genvar v = 0; v < VC_NUM; v++) begin : g_vc
    logic crd_inc;
    logic crd_dec;

    assign vc_avail[v] = (cnt_q[v] != '0);

    assign crd_inc = lcrd_i.v && (lcrd_i.id == vc_id_t'(v));
    assign crd_dec = take_i && (vc_id_o == vc_id_t'(v));

    // take and return on the same vc cancel out
    always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
        cnt_q[v] <= crd_cnt_t'(VC_DEPTH);
      end else if (crd_inc && !crd_dec) begin
        cnt_q[v] <= cnt_q[v] + 1'b1;
      end else if (crd_dec && !crd_inc) begin
        cnt_q[v] <= cnt_q[v] - 1'b1;
      end
    end
  end

endmodule

// ==== src/hn_eject_fifo.sv ====
`timescale 1ns/100ps

module hn_eject_fifo
  import hn_noc_pkg::*;
#(
  parameter int VC_NUM   = 2,
  parameter int VC_DEPTH = 4
) (
  input  logic     clk,
  input  logic     rst_n_i,
  input  hn_link_t link_i,
  output logic     vld_o,
  output hn_flit_t flit_o,
  input  logic     rdy_i,
  output hn_lcrd_t lcrd_o
);

  // router holds exactly this many credits
  localparam int DEPTH = VC_NUM * VC_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [CNT_W-1:0] cnt_t;

  typedef struct packed {
    vc_id_t   vc_id;
    hn_flit_t flit;
  } entry_t;

  entry_t mem [DEPTH];
  ptr_t   wr_ptr_q;
  ptr_t   rd_ptr_q;
  cnt_t   cnt_q;
  logic   wr_en;
  logic   rd_en;
  entry_t head;

  function automatic ptr_t ptr_next(ptr_t p);
    return (p == ptr_t'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  // the route field is dropped since the flit is already home
  assign wr_en = link_i.v;
  assign rd_en = vld_o && rdy_i;

  assign head   = mem[rd_ptr_q];
  assign vld_o  = (cnt_q != '0);
  assign flit_o = head.flit;

  // credit goes back with the vc the flit came on
  assign lcrd_o.v  = rd_en;
  assign lcrd_o.id = head.vc_id;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr_q] <= '{vc_id: link_i.vc_id, flit: link_i.flit};
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (rd_en) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      if (wr_en && !rd_en) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (rd_en && !wr_en) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

endmodule

// ==== src/hn_local_port.sv ====
`timescale 1ns/100ps

module hn_local_port
  import hn_noc_pkg::*;
#(
  // vc_id_t limits VC_NUM to 4
  parameter int VC_NUM   = 2,
  parameter int VC_DEPTH = 4
) (
  input  logic                      clk,
  input  logic                      rst_n_i,
  input  node_id_t                  node_id_i,

  // home agent sending side
  input  logic     [TX_CH_NUM-1:0]  hn_tx_vld_i,
  input  hn_flit_t [TX_CH_NUM-1:0]  hn_tx_flit_i,
  output logic     [TX_CH_NUM-1:0]  hn_tx_rdy_o,

  // router sending side
  output hn_link_t [TX_CH_NUM-1:0]  tx_link_o,
  input  hn_lcrd_t [TX_CH_NUM-1:0]  tx_lcrd_i,

  // router receiving side
  input  hn_link_t [RX_CH_NUM-1:0]  rx_link_i,
  output hn_lcrd_t [RX_CH_NUM-1:0]  rx_lcrd_o,

  // home agent receiving side
  output logic     [RX_CH_NUM-1:0]  hn_rx_vld_o,
  output hn_flit_t [RX_CH_NUM-1:0]  hn_rx_flit_o,
  input  logic     [RX_CH_NUM-1:0]  hn_rx_rdy_i
);

  // injection paths for resp, data and snp
  logic     [TX_CH_NUM-1:0] tx_hsk;
  hn_flit_t [TX_CH_NUM-1:0] tx_dec_flit;
  io_port_t [TX_CH_NUM-1:0] tx_dec_route;
  vc_id_t   [TX_CH_NUM-1:0] tx_vc_id;

  for (genvar i = 0; i < TX_CH_NUM; i++) begin : g_tx

    hn_route_dec u_route_dec (
      .node_id_i (node_id_i),
      .flit_i    (hn_tx_flit_i[i]),
      .flit_o    (tx_dec_flit[i]),
      .route_o   (tx_dec_route[i])
    );

    hn_credit_tracker #(
      .VC_NUM   (VC_NUM),
      .VC_DEPTH (VC_DEPTH)
    ) u_credit_tracker (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .take_i  (tx_hsk[i]),
      .lcrd_i  (tx_lcrd_i[i]),
      .rdy_o   (hn_tx_rdy_o[i]),
      .vc_id_o (tx_vc_id[i])
    );

    // rdy is registered, so the link follows vld in the same cycle
    assign tx_hsk[i] = hn_tx_vld_i[i] && hn_tx_rdy_o[i];

    assign tx_link_o[i] = '{
      v:     tx_hsk[i],
      vc_id: tx_vc_id[i],
      route: tx_dec_route[i],
      flit:  tx_dec_flit[i]
    };
  end

  // ejection paths for req, resp, evict and data
  for (genvar i = 0; i < RX_CH_NUM; i++) begin : g_rx

    hn_eject_fifo #(
      .VC_NUM   (VC_NUM),
      .VC_DEPTH (VC_DEPTH)
    ) u_eject_fifo (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .link_i  (rx_link_i[i]),
      .vld_o   (hn_rx_vld_o[i]),
      .flit_o  (hn_rx_flit_o[i]),
      .rdy_i   (hn_rx_rdy_i[i]),
      .lcrd_o  (rx_lcrd_o[i])
    );
  end

endmodule

// ==== bench/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// galois lfsr stepped once per random bit
logic [31:0] lfsr_q = 32'h9bd5_fe2b;

function automatic logic lfsr_step();
  logic out;
  out = lfsr_q[0];
  lfsr_q = lfsr_q >> 1;
  if (out) begin
    lfsr_q = lfsr_q ^ 32'h8020_0003;
  end
  return out;
endfunction

function automatic logic [31:0] rand_bits(int n);
  logic [31:0] r;
  r = '0;
  for (int i = 0; i < n; i++) begin
    r = {r[30:0], lfsr_step()};
  end
  return r;
endfunction

task automatic check_flit(string what, hn_flit_t exp, hn_flit_t act);
  if (act !== exp) begin
    $display("ERROR %s %s: expected %h actual %h", test_name, what, exp, act);
    fail_run();
  end
endtask

task automatic check_port(string what, io_port_t exp, io_port_t act);
  if (act !== exp) begin
    $display("ERROR %s %s: expected %0d actual %0d", test_name, what, exp, act);
    fail_run();
  end
endtask

task automatic check_vc(string what, vc_id_t exp, vc_id_t act);
  if (act !== exp) begin
    $display("ERROR %s %s: expected %0d actual %0d", test_name, what, exp, act);
    fail_run();
  end
endtask

task automatic check_bit(string what, logic exp, logic act);
  if (act !== exp) begin
    $display("ERROR %s %s: expected %b actual %b", test_name, what, exp, act);
    fail_run();
  end
endtask

`endif

// ==== bench/tb_hn_local_port.sv ====
`timescale 1ns/100ps

module tb_hn_local_port
  import hn_noc_pkg::*;
();

  localparam int       VC_NUM      = 2;
  localparam int       VC_DEPTH    = 4;
  localparam int       DEPTH       = VC_NUM * VC_DEPTH;
  localparam node_id_t NODE_ID     = 6'b011_100;
  localparam int       DEC_N       = 40;
  localparam int       EXH_N       = DEPTH + 2;
  localparam int       EJ_N        = 40;
  localparam int       MIX_N       = 30;
  localparam int       TOTAL_FLITS = TX_CH_NUM * DEC_N + EXH_N + EJ_N
                                     + (TX_CH_NUM + RX_CH_NUM) * MIX_N;
  localparam int       CYCLE_LIMIT = 20 * TOTAL_FLITS + 200;

  typedef struct packed {
    vc_id_t   vc;
    hn_flit_t flit;
  } rx_ent_t;

  logic                     clk;
  logic                     rst_n_i;
  node_id_t                 node_id_i;
  logic     [TX_CH_NUM-1:0] hn_tx_vld_i;
  hn_flit_t [TX_CH_NUM-1:0] hn_tx_flit_i;
  logic     [TX_CH_NUM-1:0] hn_tx_rdy_o;
  hn_link_t [TX_CH_NUM-1:0] tx_link_o;
  hn_lcrd_t [TX_CH_NUM-1:0] tx_lcrd_i;
  hn_link_t [RX_CH_NUM-1:0] rx_link_i;
  hn_lcrd_t [RX_CH_NUM-1:0] rx_lcrd_o;
  logic     [RX_CH_NUM-1:0] hn_rx_vld_o;
  hn_flit_t [RX_CH_NUM-1:0] hn_rx_flit_o;
  logic     [RX_CH_NUM-1:0] hn_rx_rdy_i;

  string   test_name;
  int      cycles = 0;
  int      tx_left    [TX_CH_NUM];
  logic    tx_cont    [TX_CH_NUM];
  logic    ret_en     [TX_CH_NUM];
  logic    man_ret    [TX_CH_NUM];
  vc_id_t  man_vc     [TX_CH_NUM];
  logic    tx_hsk_q   [TX_CH_NUM];
  int      tx_sent    [TX_CH_NUM];
  vc_id_t  tx_vc_last [TX_CH_NUM];
  int      mcrd       [TX_CH_NUM][VC_NUM];
  vc_id_t  ret_q      [TX_CH_NUM][$];
  int      rx_left    [RX_CH_NUM];
  int      rcrd       [RX_CH_NUM][VC_NUM];
  rx_ent_t rx_exp_q   [RX_CH_NUM][$];

  hn_local_port #(
    .VC_NUM   (VC_NUM),
    .VC_DEPTH (VC_DEPTH)
  ) DUT (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .node_id_i    (node_id_i),
    .hn_tx_vld_i  (hn_tx_vld_i),
    .hn_tx_flit_i (hn_tx_flit_i),
    .hn_tx_rdy_o  (hn_tx_rdy_o),
    .tx_link_o    (tx_link_o),
    .tx_lcrd_i    (tx_lcrd_i),
    .rx_link_i    (rx_link_i),
    .rx_lcrd_o    (rx_lcrd_o),
    .hn_rx_vld_o  (hn_rx_vld_o),
    .hn_rx_flit_o (hn_rx_flit_o),
    .hn_rx_rdy_i  (hn_rx_rdy_i)
  );

  task automatic fail_run();
    $display("Something failed");
    $fatal(1);
  endtask

  `include "tb_checks.svh"

  // x first, then y
  function automatic io_port_t ref_route(node_id_t own, node_id_t tgt);
    if (tgt.x != own.x) begin
      return (tgt.x > own.x) ? E : W;
    end
    if (tgt.y != own.y) begin
      return (tgt.y > own.y) ? N : S;
    end
    return L;
  endfunction

  function automatic hn_flit_t ref_stamp(node_id_t own, hn_flit_t f);
    hn_flit_t s;
    s = f;
    s.src_id = own;
    return s;
  endfunction

  function automatic logic ref_rdy(int c);
    for (int v = 0; v < VC_NUM; v++) begin
      if (mcrd[c][v] > 0) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  function automatic vc_id_t ref_vc(int c);
    for (int v = 0; v < VC_NUM; v++) begin
      if (mcrd[c][v] > 0) begin
        return vc_id_t'(v);
      end
    end
    return '0;
  endfunction

  function automatic hn_flit_t new_flit();
    hn_flit_t    f;
    logic [31:0] r;
    r = rand_bits(6);
    f.tgt_id = r[5:0];
    // some flits target this tile
    if (rand_bits(3) == 32'd0) begin
      f.tgt_id = NODE_ID;
    end
    r = rand_bits(6);
    f.src_id = r[5:0];
    r = rand_bits(5);
    f.opcode = r[4:0];
    r = rand_bits(TXN_ID_W);
    f.txn_id = r[TXN_ID_W-1:0];
    f.payload = rand_bits(32);
    return f;
  endfunction

  // settle point between the edges
  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic return_one_credit(int c, vc_id_t k);
    int idx;
    idx = -1;
    for (int i = 0; i < ret_q[c].size(); i++) begin
      if (idx < 0 && ret_q[c][i] == k) begin
        idx = i;
      end
    end
    if (idx < 0) begin
      $display("no outstanding credit on VC %0d of channel %0d", k, c);
      fail_run();
    end
    ret_q[c].delete(idx);
    man_vc[c] = k;
    man_ret[c] = 1'b1;
  endtask

  task automatic wait_idle();
    logic busy;
    busy = 1'b1;
    while (busy) begin
      step();
      busy = 1'b0;
      for (int c = 0; c < TX_CH_NUM; c++) begin
        if (tx_left[c] > 0 || hn_tx_vld_i[c] || ret_q[c].size() > 0 || man_ret[c]) begin
          busy = 1'b1;
        end
      end
      for (int r = 0; r < RX_CH_NUM; r++) begin
        if (rx_left[r] > 0 || rx_exp_q[r].size() > 0) begin
          busy = 1'b1;
        end
      end
    end
    repeat (3) step();
  endtask

  task automatic count_check(int c, int exp);
    if (tx_sent[c] != exp) begin
      $display("ERROR %s accepted flits on channel %0d: expected %0d actual %0d",
               test_name, c, exp, tx_sent[c]);
      fail_run();
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin : watchdog
    cycles = cycles + 1;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      fail_run();
    end
  end

  // home agent and router models
  always @(posedge clk) begin : drive
    hn_link_t    lnk;
    vc_id_t      vc;
    logic [31:0] r;
    if (rst_n_i) begin
      for (int c = 0; c < TX_CH_NUM; c++) begin
        // vld is held until the flit is taken
        if (!hn_tx_vld_i[c] || tx_hsk_q[c]) begin
          if (tx_left[c] > 0 && (tx_cont[c] || lfsr_step())) begin
            hn_tx_vld_i[c] <= 1'b1;
            hn_tx_flit_i[c] <= new_flit();
            tx_left[c]--;
          end else begin
            hn_tx_vld_i[c] <= 1'b0;
          end
        end
        if (man_ret[c]) begin
          tx_lcrd_i[c] <= '{v: 1'b1, id: man_vc[c]};
          man_ret[c] = 1'b0;
        end else if (ret_en[c] && ret_q[c].size() > 0 && lfsr_step()) begin
          tx_lcrd_i[c] <= '{v: 1'b1, id: ret_q[c].pop_front()};
        end else begin
          tx_lcrd_i[c] <= '0;
        end
      end
      for (int i = 0; i < RX_CH_NUM; i++) begin
        lnk = '0;
        if (rx_left[i] > 0 && lfsr_step()) begin
          r = rand_bits(VC_ID_W);
          vc = vc_id_t'(r % VC_NUM);
          // router only sends on a vc it holds credit for
          if (rcrd[i][vc] > 0) begin
            r = rand_bits(2);
            lnk.v = 1'b1;
            lnk.vc_id = vc;
            lnk.route = io_port_t'(r[2:0]);
            lnk.flit = new_flit();
            rcrd[i][vc]--;
            rx_left[i]--;
            rx_exp_q[i].push_back('{vc: vc, flit: lnk.flit});
          end
        end
        rx_link_i[i] <= lnk;
        hn_rx_rdy_i[i] <= lfsr_step();
      end
    end
  end

  always @(negedge clk) begin : compare
    logic    hsk;
    logic    dep;
    logic    exp_vld;
    vc_id_t  exp_vc;
    rx_ent_t ent;
    if (rst_n_i) begin
      for (int c = 0; c < TX_CH_NUM; c++) begin
        check_bit("tx ready", ref_rdy(c), hn_tx_rdy_o[c]);
        hsk = hn_tx_vld_i[c] && ref_rdy(c);
        check_bit("tx link valid", hsk, tx_link_o[c].v);
        if (hsk) begin
          exp_vc = ref_vc(c);
          check_flit("tx flit", ref_stamp(NODE_ID, hn_tx_flit_i[c]), tx_link_o[c].flit);
          check_port("tx route", ref_route(NODE_ID, hn_tx_flit_i[c].tgt_id),
                     tx_link_o[c].route);
          check_vc("tx vc", exp_vc, tx_link_o[c].vc_id);
          mcrd[c][exp_vc]--;
          ret_q[c].push_back(exp_vc);
        end
        // accepted flits as seen on the DUT ports
        if (hn_tx_vld_i[c] && hn_tx_rdy_o[c]) begin
          tx_sent[c]++;
          tx_vc_last[c] = tx_link_o[c].vc_id;
        end
        if (tx_lcrd_i[c].v) begin
          mcrd[c][tx_lcrd_i[c].id]++;
        end
        tx_hsk_q[c] = hsk;
      end
      for (int i = 0; i < RX_CH_NUM; i++) begin
        // a flit on the link now is only written at the next edge
        exp_vld = rx_exp_q[i].size() > int'(rx_link_i[i].v);
        check_bit("rx valid", exp_vld, hn_rx_vld_o[i]);
        dep = hn_rx_vld_o[i] && hn_rx_rdy_i[i];
        check_bit("rx credit valid", dep, rx_lcrd_o[i].v);
        if (dep) begin
          ent = rx_exp_q[i].pop_front();
          check_flit("rx flit", ent.flit, hn_rx_flit_o[i]);
          check_vc("rx credit vc", ent.vc, rx_lcrd_o[i].id);
          rcrd[i][ent.vc]++;
        end
      end
    end
  end

  initial begin
    int base;
    test_name = "reset";
    for (int c = 0; c < TX_CH_NUM; c++) begin
      tx_left[c] = 0;
      tx_cont[c] = 1'b0;
      ret_en[c] = 1'b1;
      man_ret[c] = 1'b0;
      man_vc[c] = '0;
      tx_hsk_q[c] = 1'b0;
      tx_sent[c] = 0;
      tx_vc_last[c] = '0;
      for (int v = 0; v < VC_NUM; v++) begin
        mcrd[c][v] = VC_DEPTH;
      end
    end
    for (int i = 0; i < RX_CH_NUM; i++) begin
      rx_left[i] = 0;
      for (int v = 0; v < VC_NUM; v++) begin
        rcrd[i][v] = VC_DEPTH;
      end
    end
    rst_n_i <= 1'b0;
    node_id_i <= NODE_ID;
    hn_tx_vld_i <= '0;
    hn_tx_flit_i <= '0;
    tx_lcrd_i <= '0;
    rx_link_i <= '0;
    hn_rx_rdy_i <= '0;
    repeat (4) @(posedge clk);
    rst_n_i <= 1'b1;
    step();

    for (int c = 0; c < TX_CH_NUM; c++) begin
      check_bit("tx link valid", 1'b0, tx_link_o[c].v);
      check_bit("tx ready", 1'b1, hn_tx_rdy_o[c]);
    end
    for (int i = 0; i < RX_CH_NUM; i++) begin
      check_bit("rx credit valid", 1'b0, rx_lcrd_o[i].v);
      check_bit("rx valid", 1'b0, hn_rx_vld_o[i]);
    end

    test_name = "injection decode";
    for (int c = 0; c < TX_CH_NUM; c++) begin
      tx_left[c] = DEC_N;
    end
    wait_idle();

    // no returns, so the channel runs dry after DEPTH flits
    test_name = "credit exhaustion";
    base = tx_sent[TX_DATA];
    ret_en[TX_DATA] = 1'b0;
    tx_cont[TX_DATA] = 1'b1;
    tx_left[TX_DATA] = EXH_N;
    while (tx_sent[TX_DATA] < base + DEPTH) begin
      step();
    end
    repeat (10) step();
    count_check(TX_DATA, base + DEPTH);
    check_bit("tx ready when empty", 1'b0, hn_tx_rdy_o[TX_DATA]);
    return_one_credit(TX_DATA, vc_id_t'(VC_NUM - 1));
    while (tx_sent[TX_DATA] < base + DEPTH + 1) begin
      step();
    end
    check_vc("vc after one return", vc_id_t'(VC_NUM - 1), tx_vc_last[TX_DATA]);
    repeat (10) step();
    count_check(TX_DATA, base + DEPTH + 1);
    ret_en[TX_DATA] = 1'b1;
    tx_cont[TX_DATA] = 1'b0;
    wait_idle();

    test_name = "ejection back-pressure";
    rx_left[RX_REQ] = EJ_N;
    wait_idle();

    test_name = "independent channels";
    for (int c = 0; c < TX_CH_NUM; c++) begin
      tx_left[c] = MIX_N;
    end
    for (int i = 0; i < RX_CH_NUM; i++) begin
      rx_left[i] = MIX_N;
    end
    wait_idle();

    $display("Everything OK");
    $finish;
  end

endmodule

// ==== hn_local_port.f ====
+incdir+bench
src/hn_noc_pkg.sv
src/hn_route_dec.sv
src/hn_credit_tracker.sv
src/hn_eject_fifo.sv
src/hn_local_port.sv
bench/tb_hn_local_port.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the hn_local_port testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
  -f hn_local_port.f \
  --top-module tb_hn_local_port \
  -Mdir obj_dir -o sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Everything OK"; then
  exit 0
else
  exit 1
fi
